// File: compile.f
+incdir+hw
hw/ddr_phy_pkg.sv
hw/ddr_write_path.sv
hw/ddr_read_path.sv
hw/ddr_phy_top.sv
tb/tb_clk_gen.sv
tb/tb_ddr_phy.sv

// File: hw/ddr_phy_config.svh
// Build-time sizes and options of the DDR PHY pad logic, included by the package and the RTL
`ifndef DDR_PHY_CONFIG_SVH
`define DDR_PHY_CONFIG_SVH

// ##########################################################################
// DQ group geometry
// ##########################################################################

// Number of DQ pins in the group
`define DDR_PIN_WIDTH 8

// Beats carried by one half-rate word
`define DDR_HR_BEATS 4

// Beats carried by one full-rate pad cycle, low and high
`define DDR_FR_BEATS 2

// ##########################################################################
// Read capture options
// ##########################################################################

// 1 swaps the low and high beat of every sampled pad pair
`define DDR_REVERSE_READ_WORDS 0

`endif

// File: hw/ddr_phy_pkg.sv
// Shared packed types for half-rate controller words and full-rate pad signals
`default_nettype none

`include "ddr_phy_config.svh"

package ddr_phy_pkg;

    // One beat across every DQ pin
    typedef logic [`DDR_PIN_WIDTH-1:0] dq_beat_t;

    // ######################################################################
    // Controller side, half rate
    // ######################################################################

    // Write request, t0 is the first beat on the wire
    typedef struct packed {
        logic [1:0]               dqs_en;   // DQS enable per full-rate cycle
        logic [`DDR_PIN_WIDTH-1:0] oe1;     // DQ enable, second cycle
        logic [`DDR_PIN_WIDTH-1:0] oe0;     // DQ enable, first cycle
        dq_beat_t                 t3;
        dq_beat_t                 t2;
        dq_beat_t                 t1;
        dq_beat_t                 t0;
    } hr_wr_word_t;

    // Read word assembled from two pad cycles
    typedef struct packed {
        dq_beat_t t3;
        dq_beat_t t2;
        dq_beat_t t1;
        dq_beat_t t0;
    } hr_rd_word_t;

    // ######################################################################
    // Pad side, full rate
    // ######################################################################

    typedef struct packed {
        logic                      dqs_oe;  // Drives the DQS buffer enable
        logic [`DDR_PIN_WIDTH-1:0] dq_oe;   // Per-pin DQ enable
        dq_beat_t                  hi;      // Beat launched on the falling half
        dq_beat_t                  lo;      // Beat launched on the rising half
    } fr_pad_out_t;

    typedef struct packed {
        dq_beat_t hi;
        dq_beat_t lo;
    } fr_pad_in_t;

endpackage

`default_nettype wire

// File: hw/ddr_phy_top.sv
// DDR PHY DQ/DQS pad logic top, joins the write and read paths between controller and pads
`default_nettype none
`timescale 1ns/1ps

module ddr_phy_top (
    input  wire                          pll_mem_clk,
    input  wire                          rst_n,

    // ######################################################################
    // Controller side
    // ######################################################################
    input  wire ddr_phy_pkg::hr_wr_word_t wr_word,
    input  wire                          wr_strobe,
    output ddr_phy_pkg::hr_rd_word_t     rd_word,
    output logic                         rd_strobe,

    // ######################################################################
    // Pad side
    // ######################################################################
    output ddr_phy_pkg::fr_pad_out_t     pad_out,
    input  wire ddr_phy_pkg::fr_pad_in_t pad_in,
    input  wire                          rd_capture
);

    // Controller to pads
    ddr_write_path i_write_path (
        .pll_mem_clk (pll_mem_clk),
        .rst_n       (rst_n),
        .wr_word     (wr_word),
        .wr_strobe   (wr_strobe),
        .pad_out     (pad_out)
    );

    // Pads to controller
    ddr_read_path i_read_path (
        .pll_mem_clk (pll_mem_clk),
        .rst_n       (rst_n),
        .pad_in      (pad_in),
        .rd_capture  (rd_capture),
        .rd_word     (rd_word),
        .rd_strobe   (rd_strobe)
    );

endmodule

`default_nettype wire

// File: hw/ddr_read_path.sv
// Read capture instantiated by the PHY top to pair full-rate pad samples into half-rate words
`default_nettype none
`timescale 1ns/1ps

`include "ddr_phy_config.svh"

module ddr_read_path (
    input  wire                       pll_mem_clk,
    input  wire                       rst_n,
    input  wire ddr_phy_pkg::fr_pad_in_t pad_in,
    input  wire                       rd_capture,   // High while sampling
    output ddr_phy_pkg::hr_rd_word_t  rd_word,
    output logic                      rd_strobe     // One cycle per assembled word
);

    import ddr_phy_pkg::*;

    localparam bit REVERSE = (`DDR_REVERSE_READ_WORDS != 0);

    fr_pad_in_t smp;          // Pad pair after the optional swap
    fr_pad_in_t first_q;      // First half of the pair being built
    logic       cap_q;        // rd_capture one cycle ago
    logic       phase_q;      // Set while the second half is expected
    logic       is_first;

    // ######################################################################
    // Sample ordering and pair phase
    // ######################################################################

    always_comb
    begin
        if (REVERSE)
        begin
            smp.lo = pad_in.hi;
            smp.hi = pad_in.lo;
        end
        else
            smp = pad_in;

        // Rising edge of capture always starts a new pair
        is_first = ~cap_q | ~phase_q;
    end

    // First half of each pair
    always_ff @(posedge pll_mem_clk)
    begin
        if (rd_capture && is_first)
            first_q <= smp;
    end

    // ######################################################################
    // Word assembly
    // ######################################################################

    always_ff @(posedge pll_mem_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            cap_q     <= 1'b0;
            phase_q   <= 1'b0;
            rd_strobe <= 1'b0;
            rd_word   <= '0;
        end
        else
        begin
            cap_q     <= rd_capture;
            rd_strobe <= rd_capture & ~is_first;
            if (rd_capture)
            begin
                phase_q <= is_first;   // An odd leftover stays parked here
                if (!is_first)
                begin
                    rd_word.t0 <= first_q.lo;
                    rd_word.t1 <= first_q.hi;
                    rd_word.t2 <= smp.lo;
                    rd_word.t3 <= smp.hi;
                end
            end
        end
    end

    // ######################################################################
    // Checks
    // ######################################################################

    // Each word needs two samples
    a_strobe_gap: assert property (
        @(posedge pll_mem_clk) disable iff (!rst_n)
        rd_strobe |=> !rd_strobe
    )
    else
        $error("rd_strobe pulsed on two consecutive cycles");

endmodule

`default_nettype wire

// File: hw/ddr_write_path.sv
// Write serializer instantiated by the PHY top to put half-rate words onto full-rate pad cycles
`default_nettype none
`timescale 1ns/1ps

`include "ddr_phy_config.svh"

module ddr_write_path (
    input  wire                        pll_mem_clk,
    input  wire                        rst_n,
    input  wire ddr_phy_pkg::hr_wr_word_t wr_word,
    input  wire                        wr_strobe,  // Single cycle without back-pressure
    output ddr_phy_pkg::fr_pad_out_t   pad_out
);

    import ddr_phy_pkg::*;

    // ######################################################################
    // Word hold and phase
    // ######################################################################

    hr_wr_word_t word_q;      // Accepted word that supplies the second half
    logic        phase_q;     // Set while the second half is due

    // Pad mux inputs
    hr_wr_word_t                  src;
    dq_beat_t [`DDR_HR_BEATS-1:0] src_beats;
    logic                         half;       // Selects the second beat pair
    int unsigned                  pair_base;
    logic                         wr_active;

    logic dqs_fr_q;           // DQS enable before the extra stage

    // Word capture on the strobe
    always_ff @(posedge pll_mem_clk)
    begin
        if (wr_strobe)
            word_q <= wr_word;
    end

    // Phase restarts on every strobe and falls back to idle after the second half
    always_ff @(posedge pll_mem_clk or negedge rst_n)
    begin
        if (!rst_n)
            phase_q <= 1'b0;
        else
            phase_q <= wr_strobe;
    end

    // ######################################################################
    // Half-rate to full-rate select
    // ######################################################################

    always_comb
    begin
        // A new word goes straight to the pads while the held one supplies the rest
        src       = wr_strobe ? wr_word : word_q;
        half      = phase_q & ~wr_strobe;
        wr_active = wr_strobe | phase_q;
        src_beats = {src.t3, src.t2, src.t1, src.t0};
        pair_base = `DDR_FR_BEATS * 32'(half);
    end

    // ######################################################################
    // Pad registers
    // ######################################################################

    always_ff @(posedge pll_mem_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pad_out  <= '0;
            dqs_fr_q <= 1'b0;
        end
        else
        begin
            pad_out.dq_oe <= wr_active ? (half ? src.oe1 : src.oe0) : '0;

            dqs_fr_q       <= wr_active & src.dqs_en[half];
            pad_out.dqs_oe <= dqs_fr_q;   // DQS enable trails the data by one cycle

            // Beats hold their last value while idle
            if (wr_active)
            begin
                pad_out.lo <= src_beats[pair_base];
                pad_out.hi <= src_beats[pair_base + 1];
            end
        end
    end

    // ######################################################################
    // Checks
    // ######################################################################

    // A word occupies two pad cycles so strobes need a one-cycle gap
    a_strobe_spacing: assert property (
        @(posedge pll_mem_clk) disable iff (!rst_n)
        wr_strobe |=> !wr_strobe
    )
    else
        $error("wr_strobe asserted on two consecutive cycles");

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the DDR PHY testbench with Verilator, runs it and checks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_ddr_phy -f compile.f -Mdir obj_dir
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

sim_output=$(./obj_dir/Vtb_ddr_phy)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -qx "TEST RESULT: PASS"; then
    exit 0
else
    echo "Pass line not found in simulation output"
    exit 1
fi

// File: tb/ddr_phy_stim.txt
# W t0 t1 t2 t3 oe0 oe1 dqs_en gap : write word in hex, gap is idle cycles after its strobe
# R n : capture run of n cycles, then n lines of pad beats "lo hi" in hex
W 11 22 33 44 ff ff 3 6
W a5 5a c3 3c 0f f0 1 6
W 01 02 03 04 ff 00 2 6
W 10 20 30 40 ff ff 3 1
W 50 60 70 80 ff ff 3 1
W 90 a0 b0 c0 aa 55 3 6
R 4
de ad
be ef
12 34
56 78
R 3
a1 b2
c3 d4
e5 f6
R 2
0f f0
77 88
W fe dc ba 98 33 cc 0 6
R 6
01 80
02 40
04 20
08 10
10 08
20 04

// File: tb/tb_clk_gen.sv
// Testbench clock and reset source, 20 ns clock with reset held low for the first four cycles
`default_nettype none
`timescale 1ns/1ps

module tb_clk_gen (
    output logic pll_mem_clk,
    output logic rst_n
);

    initial
    begin
        pll_mem_clk = 1'b0;
        forever #10 pll_mem_clk = ~pll_mem_clk;   // 20 ns period
    end

    initial
    begin
        rst_n = 1'b0;
        repeat (4) @(posedge pll_mem_clk);
        rst_n <= 1'b1;                            // Released on a rising edge
    end

endmodule

`default_nettype wire

// File: tb/tb_ddr_phy.sv
// Testbench for the DDR PHY pad logic, replays the stimulus file and checks pads and read words
`default_nettype none
`timescale 1ns/1ps

`include "ddr_phy_config.svh"

module tb_ddr_phy;

    import ddr_phy_pkg::*;

    localparam string STIM_FILE = "tb/ddr_phy_stim.txt";

    logic        pll_mem_clk;
    logic        rst_n;
    hr_wr_word_t wr_word;
    logic        wr_strobe;
    fr_pad_in_t  pad_in;
    logic        rd_capture;
    fr_pad_out_t pad_out;
    hr_rd_word_t rd_word;
    logic        rd_strobe;

    // Stimulus records in file order
    byte         kind_q[$];
    hr_wr_word_t wr_q[$];
    int          gap_q[$];
    int          len_q[$];
    fr_pad_in_t  pad_q[$];
    int          total_cycles = 0;
    int          wd_limit = 0;

    // Expected results keyed by cycle after reset
    fr_pad_out_t dq_sched[int];
    logic        dqs_sched[int];
    hr_rd_word_t rd_sched[int];
    int          cyc = 0;
    dq_beat_t    last_lo = '0;
    dq_beat_t    last_hi = '0;
    logic        pair_open = 1'b0;
    fr_pad_in_t  pair_first;

    // Monitor scratch
    fr_pad_out_t exp_pad;
    fr_pad_out_t nxt_pad;
    fr_pad_in_t  smp;
    hr_rd_word_t exp_word;
    logic        exp_strobe;

    int n_checks = 0;
    int n_errors = 0;
    int test_no = 0;
    int tests_failed = 0;
    int test_err_base = 0;

    tb_clk_gen i_clk_gen (
        .pll_mem_clk (pll_mem_clk),
        .rst_n       (rst_n)
    );

    ddr_phy_top i_dut (
        .pll_mem_clk (pll_mem_clk),
        .rst_n       (rst_n),
        .wr_word     (wr_word),
        .wr_strobe   (wr_strobe),
        .rd_word     (rd_word),
        .rd_strobe   (rd_strobe),
        .pad_out     (pad_out),
        .pad_in      (pad_in),
        .rd_capture  (rd_capture)
    );

    // ######################################################################
    // Compare tasks
    // ######################################################################

    task automatic check_pad_out(input fr_pad_out_t exp, input fr_pad_out_t act);
        n_checks++;
        if (act !== exp)
        begin
            n_errors++;
            $display("[FAIL] pad_out cycle %0d exp lo=%h hi=%h dq_oe=%h dqs_oe=%h", cyc,
                     exp.lo, exp.hi, exp.dq_oe, exp.dqs_oe,
                     " got lo=%h hi=%h dq_oe=%h dqs_oe=%h",
                     act.lo, act.hi, act.dq_oe, act.dqs_oe);
        end
    endtask

    task automatic check_rd_strobe(input logic exp, input logic act);
        n_checks++;
        if (act !== exp)
        begin
            n_errors++;
            $display("[FAIL] rd_strobe cycle %0d exp %h got %h", cyc, exp, act);
        end
    endtask

    task automatic check_rd_word(input hr_rd_word_t exp, input hr_rd_word_t act);
        n_checks++;
        if (act !== exp)
        begin
            n_errors++;
            $display("[FAIL] rd_word cycle %0d exp %h got %h", cyc, exp, act);
        end
    endtask

    // ######################################################################
    // Stimulus file and drivers
    // ######################################################################

    task automatic load_stimulus(output bit ok);
        int               fd;
        int               code;
        int               gap;
        int               len;
        logic [7:0]       kind;
        logic [8*128-1:0] line;
        logic [31:0]      v0, v1, v2, v3, v4, v5, v6;
        hr_wr_word_t      w;
        fr_pad_in_t       p;
        bit               done;
        bit               bad;
        ok   = 1'b0;
        done = 1'b0;
        bad  = 1'b0;
        fd   = $fopen(STIM_FILE, "r");
        if (fd == 0)
            return;
        while (!done)
        begin
            code = $fscanf(fd, " %c", kind);
            if (code != 1)
                done = 1'b1;
            else if (kind == "#")
                code = $fgets(line, fd);              // Column notes
            else if (kind == "W")
            begin
                code = $fscanf(fd, "%h %h %h %h %h %h %h %d",
                               v0, v1, v2, v3, v4, v5, v6, gap);
                w.t0     = v0[$bits(dq_beat_t)-1:0];
                w.t1     = v1[$bits(dq_beat_t)-1:0];
                w.t2     = v2[$bits(dq_beat_t)-1:0];
                w.t3     = v3[$bits(dq_beat_t)-1:0];
                w.oe0    = v4[$bits(dq_beat_t)-1:0];
                w.oe1    = v5[$bits(dq_beat_t)-1:0];
                w.dqs_en = v6[1:0];
                bad  = (code != 8) || (gap < 1);      // Strobes need a one-cycle gap
                done = bad;
                kind_q.push_back(kind);
                wr_q.push_back(w);
                gap_q.push_back(gap);
                total_cycles += gap + 1;
            end
            else if (kind == "R")
            begin
                code = $fscanf(fd, "%d", len);
                for (int i = 0; i < len; i++)
                begin
                    code = $fscanf(fd, "%h %h", v0, v1);
                    p.lo = v0[$bits(dq_beat_t)-1:0];
                    p.hi = v1[$bits(dq_beat_t)-1:0];
                    pad_q.push_back(p);
                end
                kind_q.push_back(kind);
                len_q.push_back(len);
                total_cycles += len + 2;
            end
            else
            begin
                bad  = 1'b1;
                done = 1'b1;
            end
        end
        $fclose(fd);
        ok = !bad && (kind_q.size() > 0);
    endtask

    task automatic drive_write(input hr_wr_word_t w, input int gap);
        @(posedge pll_mem_clk);
        wr_word   <= w;
        wr_strobe <= 1'b1;
        @(posedge pll_mem_clk);
        wr_strobe <= 1'b0;
        repeat (gap - 1) @(posedge pll_mem_clk);
    endtask

    task automatic drive_read(input int len);
        fr_pad_in_t p;
        repeat (len)
        begin
            p = pad_q.pop_front();
            @(posedge pll_mem_clk);
            rd_capture <= 1'b1;
            pad_in     <= p;
        end
        @(posedge pll_mem_clk);
        rd_capture <= 1'b0;
        @(posedge pll_mem_clk);                       // Last strobe lands before this edge
    endtask

    task automatic begin_test();
        test_no++;
        test_err_base = n_errors;
    endtask

    task automatic end_test(input string what);
        if (n_errors == test_err_base)
            $display("test %0d ok: %s", test_no, what);
        else
        begin
            tests_failed++;
            $display("test %0d failed with %0d errors: %s", test_no,
                     n_errors - test_err_base, what);
        end
    endtask

    // ######################################################################
    // Reference model, runs between rising edges
    // ######################################################################

    always @(negedge pll_mem_clk)
    begin
        if (rst_n === 1'b1)
        begin
            cyc = cyc + 1;

            if (dq_sched.exists(cyc))
            begin
                exp_pad = dq_sched[cyc];
                dq_sched.delete(cyc);
                last_lo = exp_pad.lo;
                last_hi = exp_pad.hi;
            end
            else
            begin
                exp_pad    = '0;                      // Idle, beats hold
                exp_pad.lo = last_lo;
                exp_pad.hi = last_hi;
            end
            exp_pad.dqs_oe = 1'b0;
            if (dqs_sched.exists(cyc))
            begin
                exp_pad.dqs_oe = dqs_sched[cyc];
                dqs_sched.delete(cyc);
            end
            check_pad_out(exp_pad, pad_out);

            exp_strobe = rd_sched.exists(cyc);
            check_rd_strobe(exp_strobe, rd_strobe);
            if (exp_strobe)
            begin
                check_rd_word(rd_sched[cyc], rd_word);
                rd_sched.delete(cyc);
            end

            // Inputs held now are taken on the next rising edge
            if (wr_strobe)
            begin
                nxt_pad.dqs_oe = 1'b0;
                nxt_pad.lo     = wr_word.t0;
                nxt_pad.hi     = wr_word.t1;
                nxt_pad.dq_oe  = wr_word.oe0;
                dq_sched[cyc + 1] = nxt_pad;
                nxt_pad.lo     = wr_word.t2;
                nxt_pad.hi     = wr_word.t3;
                nxt_pad.dq_oe  = wr_word.oe1;
                dq_sched[cyc + 2] = nxt_pad;
                dqs_sched[cyc + 2] = wr_word.dqs_en[0];
                dqs_sched[cyc + 3] = wr_word.dqs_en[1];
            end

            if (rd_capture)
            begin
                smp = pad_in;
                if (`DDR_REVERSE_READ_WORDS != 0)
                begin
                    smp.lo = pad_in.hi;
                    smp.hi = pad_in.lo;
                end
                if (pair_open)
                begin
                    exp_word.t0 = pair_first.lo;
                    exp_word.t1 = pair_first.hi;
                    exp_word.t2 = smp.lo;
                    exp_word.t3 = smp.hi;
                    rd_sched[cyc + 1] = exp_word;
                    pair_open = 1'b0;
                end
                else
                begin
                    pair_first = smp;
                    pair_open  = 1'b1;
                end
            end
            else
                pair_open = 1'b0;                     // Odd leftover is dropped
        end
    end

    // ######################################################################
    // Test sequence and watchdog
    // ######################################################################

    initial
    begin
        bit          loaded;
        byte         kind;
        hr_wr_word_t w;
        int          gap;
        int          len;
        wr_word    = '0;
        wr_strobe  = 1'b0;
        pad_in     = '0;
        rd_capture = 1'b0;
        load_stimulus(loaded);
        if (!loaded)
        begin
            $display("stimulus file %s is missing or malformed, no tests run", STIM_FILE);
            $display("TEST RESULT: FAIL");
            $finish;
        end
        else
        begin
            wd_limit = 2 * (total_cycles + 13) + 100;  // Reset, idle and drain included
            wait (rst_n === 1'b1);
            begin_test();
            repeat (3) @(posedge pll_mem_clk);
            end_test("outputs idle after reset");
            while (kind_q.size() > 0)
            begin
                kind = kind_q.pop_front();
                begin_test();
                if (kind == "W")
                begin
                    w   = wr_q.pop_front();
                    gap = gap_q.pop_front();
                    drive_write(w, gap);
                    end_test($sformatf("write %h %h %h %h oe %h/%h dqs_en %b gap %0d",
                                       w.t0, w.t1, w.t2, w.t3, w.oe0, w.oe1, w.dqs_en, gap));
                end
                else
                begin
                    len = len_q.pop_front();
                    drive_read(len);
                    end_test($sformatf("capture run of %0d cycles", len));
                end
            end
            begin_test();
            repeat (6) @(posedge pll_mem_clk);
            end_test("outputs return to idle");
            $display("tests %0d, failed %0d, checks %0d, errors %0d",
                     test_no, tests_failed, n_checks, n_errors);
            if (n_errors == 0 && tests_failed == 0)
                $display("TEST RESULT: PASS");
            else
                $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial
    begin
        wait (wd_limit > 0);
        repeat (wd_limit) @(posedge pll_mem_clk);
        $display("watchdog expired after %0d cycles, the run did not finish", wd_limit);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
